// ==== all.f ====
+incdir+common
common/zx_pkg.sv
common/zbus_if.sv
common/page_cfg_if.sv
hdl/zsignals.sv
ports/zports.sv
pager/pager.sv
hdl/zdos.sv
hdl/sound.sv
hdl/zx_top.sv
verif/tb_zx_top.sv

// ==== Makefile ====
SRCS := $(filter-out +incdir+%,$(shell cat all.f)) common/zx_cfg.svh

obj_dir/Vtb_zx_top: $(SRCS) all.f
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module tb_zx_top -Mdir obj_dir -o Vtb_zx_top

run: obj_dir/Vtb_zx_top
	out="$$(./obj_dir/Vtb_zx_top)"; echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== verif/tb_zx_top.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module tb_zx_top;
	import zx_pkg::*;

	localparam int HOLD     = 6;
	localparam int GAP      = 6;
	localparam int WAIT_MAX = 20;

	logic                  fclk;
	logic                  rst;
	logic                  iorq_n, mreq_n, m1_n, rd_n, wr_n;
	logic [`ZX_ADDR_W-1:0] a;
	logic [`ZX_DATA_W-1:0] d_in;
	logic [`ZX_DATA_W-1:0] d_out;
	logic                  d_out_en;
	logic [`ZX_PAGE_W-1:0] page;
	logic                  romnram, rw_en, dos, beep;

	// expected register state, kept in step with every write
	logic [`ZX_DATA_W-1:0] sysconf_m, memconf_m;
	logic [`ZX_PAGE_W-1:0] page_m [4];
	logic                  dos_m;

	integer seed;
	int     errors, checks, test_err0;

	zx_top u_zx_top (
		.fclk     (fclk),
		.rst      (rst),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.m1_n     (m1_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.a        (a),
		.d_in     (d_in),
		.d_out    (d_out),
		.d_out_en (d_out_en),
		.page     (page),
		.romnram  (romnram),
		.rw_en    (rw_en),
		.dos      (dos),
		.beep     (beep)
	);

	always #10 fclk = ~fclk;

	////////////////////
	// checks
	////////////////////

	task automatic compare_byte(input logic [`ZX_DATA_W-1:0] got,
		input logic [`ZX_DATA_W-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		errors++;
		$display("%0t ns: gave up waiting, %s", $time, what);
	endtask

	task automatic end_test(input string name);
		if (errors == test_err0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - test_err0);
		test_err0 = errors;
	endtask

	////////////////////
	// address helpers
	////////////////////

	function automatic port_addr_u xport(input logic [7:0] hi);
		port_addr_u p;
		p.hl.hi = hi;
		p.hl.lo = `ZX_XPORT_LO;
		return p;
	endfunction

	function automatic port_addr_u full_port(input logic [15:0] w);
		port_addr_u p;
		p.word = w;
		return p;
	endfunction

	function automatic port_addr_u mem_addr(input logic [1:0] win);
		port_addr_u p;
		p.word = {win, 14'h0ABC};
		return p;
	endfunction

	// 0 sysconf, 1 memconf, 2..5 page0..page3
	function automatic logic [7:0] reg_hi(input int i);
		if (i == 0)
			return `ZX_SYSCONF_HI;
		if (i == 1)
			return `ZX_MEMCONF_HI;
		return `ZX_PAGE0_HI + 8'(i - 2);
	endfunction

	function automatic logic [7:0] expected_reg(input int i);
		if (i == 0)
			return sysconf_m;
		if (i == 1)
			return memconf_m;
		return page_m[2'(i - 2)];
	endfunction

	////////////////////
	// cpu bus cycles
	////////////////////

	task automatic bus_idle;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
	endtask

	task automatic io_write(input port_addr_u port, input logic [`ZX_DATA_W-1:0] data);
		logic [7:0] off;
		@(posedge fclk);
		#2;
		a      = port.word;
		d_in   = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (HOLD) @(posedge fclk);
		#2;
		bus_idle();
		repeat (GAP) @(posedge fclk);
		// expected effect of the write
		off = port.hl.hi - `ZX_PAGE0_HI;
		if (port.hl.lo == `ZX_XPORT_LO) begin
			if (port.hl.hi == `ZX_SYSCONF_HI)
				sysconf_m = data;
			else if (port.hl.hi == `ZX_MEMCONF_HI)
				memconf_m = data;
			else if (off < 8'd4)
				page_m[off[1:0]] = data;
		end
		if (port.word == `ZX_P7FFD) begin
			page_m[3][2:0] = data[2:0];
			memconf_m[0]   = data[4];
		end
	endtask

	task automatic io_read(input port_addr_u port, output logic got,
		output logic [`ZX_DATA_W-1:0] data);
		got  = 1'b0;
		data = '0;
		@(posedge fclk);
		#2;
		a      = port.word;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		// d_out_en must show up while the strobes last
		for (int i = 0; i < HOLD; i++) begin
			@(negedge fclk);
			if (d_out_en && !got) begin
				got  = 1'b1;
				data = d_out;
			end
		end
		@(posedge fclk);
		#2;
		bus_idle();
		repeat (GAP) @(posedge fclk);
	endtask

	task automatic mem_cycle(input port_addr_u addr, input logic m1,
		output logic [`ZX_PAGE_W-1:0] pg, output logic rn, output logic we);
		@(posedge fclk);
		#2;
		a      = addr.word;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		m1_n   = ~m1;
		repeat (HOLD - 1) @(posedge fclk);
		@(negedge fclk);
		pg = page;
		rn = romnram;
		we = rw_en;
		@(posedge fclk);
		#2;
		bus_idle();
		repeat (GAP) @(posedge fclk);
	endtask

	task automatic check_window(input port_addr_u addr);
		logic [`ZX_PAGE_W-1:0] pg, exp_pg;
		logic                  rn, we, exp_rn, exp_we;
		logic [1:0]            win;
		mem_cycle(addr, 1'b0, pg, rn, we);
		win    = addr.word[`ZX_ADDR_W-1 -: 2];
		exp_pg = page_m[win];
		exp_rn = 1'b0;
		exp_we = 1'b1;
		// window 0 rom, low page bits from dos and rom128
		if (win == 2'd0 && !memconf_m[3]) begin
			exp_pg[1:0] = {~dos_m, memconf_m[0]};
			exp_rn      = 1'b1;
			exp_we      = memconf_m[1];
		end
		compare_byte(pg, exp_pg, "page");
		compare_bit(rn, exp_rn, "romnram");
		compare_bit(we, exp_we, "rw_en");
	endtask

	task automatic wait_dos(input logic exp);
		int n;
		n = 0;
		@(negedge fclk);
		while (dos !== exp && n < WAIT_MAX) begin
			@(negedge fclk);
			n++;
		end
		if (dos !== exp)
			note_timeout("dos never changed");
		else
			checks++;
	endtask

	task automatic wait_beep(input logic exp);
		int n;
		n = 0;
		@(negedge fclk);
		while (beep !== exp && n < WAIT_MAX) begin
			@(negedge fclk);
			n++;
		end
		if (beep !== exp)
			note_timeout("beep never followed the beeper bit");
		else
			checks++;
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_readback;
		logic [`ZX_DATA_W-1:0] rd;
		logic                  got;
		integer                r;
		@(negedge fclk);
		compare_bit(d_out_en, 1'b0, "d_out_en after reset");
		compare_bit(dos, 1'b0, "dos after reset");
		compare_bit(beep, 1'b0, "beep after reset");
		// reset values first, then random ones
		for (int pass = 0; pass < 2; pass++) begin
			if (pass == 1) begin
				for (int i = 0; i < 6; i++) begin
					r = $random(seed);
					io_write(xport(reg_hi(i)), r[7:0]);
				end
			end
			for (int i = 0; i < 6; i++) begin
				io_read(xport(reg_hi(i)), got, rd);
				if (!got)
					note_timeout("no read data from an extended port");
				else
					compare_byte(rd, expected_reg(i), "readback");
			end
		end
		io_read(xport(8'h55), got, rd);
		compare_bit(got, 1'b0, "d_out_en on unknown port");
		end_test("register readback");
	endtask

	task automatic test_windows;
		integer     r;
		logic [7:0] mc;
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			io_write(xport(`ZX_PAGE0_HI + 8'(i)), r[7:0]);
		end
		// rom, rom with w0_we, ram
		for (int j = 0; j < 3; j++) begin
			mc = (j == 0) ? 8'h00 : (j == 1) ? 8'h02 : 8'h08;
			io_write(xport(`ZX_MEMCONF_HI), mc);
			for (int w = 0; w < 4; w++)
				check_window(mem_addr(2'(w)));
		end
		end_test("window mapping");
	endtask

	task automatic test_legacy;
		integer     r;
		logic [7:0] v;
		io_write(xport(`ZX_MEMCONF_HI), 8'h00);
		for (int i = 0; i < 2; i++) begin
			r    = $random(seed);
			v    = r[7:0];
			v[4] = (i == 0);
			io_write(full_port(`ZX_P7FFD), v);
			check_window(mem_addr(2'd3));
			check_window(mem_addr(2'd0));
		end
		end_test("legacy port");
	endtask

	task automatic test_dos;
		logic [`ZX_PAGE_W-1:0] pg;
		logic                  rn, we;
		io_write(xport(`ZX_MEMCONF_HI), 8'h01);
		mem_cycle(full_port({`ZX_DOS_HI, 8'h00}), 1'b1, pg, rn, we);
		wait_dos(1'b1);
		dos_m = 1'b1;
		check_window(full_port({`ZX_DOS_HI, 8'h00}));
		// fetch outside window 0 leaves dos
		mem_cycle(full_port(16'h8000), 1'b1, pg, rn, we);
		wait_dos(1'b0);
		dos_m = 1'b0;
		check_window(mem_addr(2'd0));
		io_write(xport(`ZX_MEMCONF_HI), 8'h00);
		mem_cycle(full_port({`ZX_DOS_HI, 8'h00}), 1'b1, pg, rn, we);
		@(negedge fclk);
		compare_bit(dos, 1'b0, "dos after trap fetch without rom128");
		end_test("dos latch");
	endtask

	task automatic test_sound;
		integer     r;
		logic [7:0] v;
		logic [8:0] cnt;
		io_write(xport(`ZX_SYSCONF_HI), 8'h00);
		io_write(full_port({8'h00, `ZX_PFE}), 8'h10);
		wait_beep(1'b1);
		io_write(full_port({8'h00, `ZX_PFE}), 8'h00);
		wait_beep(1'b0);
		r = $random(seed);
		v = r[7:0];
		io_write(full_port({8'h00, `ZX_PFB}), v);
		// covox mode on
		io_write(xport(`ZX_SYSCONF_HI), 8'h10);
		cnt = '0;
		repeat (256) begin
			@(negedge fclk);
			if (beep)
				cnt = cnt + 9'd1;
		end
		compare_byte(cnt[7:0], v, "covox high count");
		compare_bit(cnt[8], 1'b0, "covox count overflow");
		end_test("sound");
	endtask

	initial begin
		seed      = 72;
		errors    = 0;
		checks    = 0;
		test_err0 = 0;
		fclk      = 1'b0;
		rst       = 1'b1;
		a         = '0;
		d_in      = '0;
		bus_idle();
		sysconf_m = '0;
		memconf_m = '0;
		page_m[0] = '0;
		page_m[1] = `ZX_PAGE1_RST;
		page_m[2] = `ZX_PAGE2_RST;
		page_m[3] = `ZX_PAGE3_RST;
		dos_m     = 1'b0;
		repeat (3) @(posedge fclk);
		#2;
		rst = 1'b0;
		test_readback();
		test_windows();
		test_legacy();
		test_dos();
		test_sound();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== hdl/zx_top.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module zx_top (
	input  logic                  fclk,
	input  logic                  rst,
	input  logic                  iorq_n,
	input  logic                  mreq_n,
	input  logic                  m1_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [`ZX_ADDR_W-1:0] a,
	input  logic [`ZX_DATA_W-1:0] d_in,
	output logic [`ZX_DATA_W-1:0] d_out,
	output logic                  d_out_en,
	output logic [`ZX_PAGE_W-1:0] page,
	output logic                  romnram,
	output logic                  rw_en,
	output logic                  dos,
	output logic                  beep
);

	logic [`ZX_DATA_W-1:0] sysconf;
	logic [`ZX_DATA_W-1:0] covox;
	logic                  beeper;
	logic                  dos_on, dos_off;

	zbus_if     u_bus ();
	page_cfg_if u_cfg ();

	////////////////////
	// cpu side
	////////////////////

	zsignals u_zsignals (
		.fclk   (fclk),
		.rst    (rst),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.m1_n   (m1_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.a      (a),
		.d_in   (d_in),
		.bus    (u_bus.source)
	);

	zports u_zports (
		.fclk     (fclk),
		.rst      (rst),
		.bus      (u_bus.sink),
		.cfg      (u_cfg.source),
		.d_out    (d_out),
		.d_out_en (d_out_en),
		.sysconf  (sysconf),
		.beeper   (beeper),
		.covox    (covox)
	);

	////////////////////
	// memory and dos
	////////////////////

	pager u_pager (
		.fclk    (fclk),
		.rst     (rst),
		.bus     (u_bus.sink),
		.cfg     (u_cfg.sink),
		.dos     (dos),
		.page    (page),
		.romnram (romnram),
		.rw_en   (rw_en),
		.dos_on  (dos_on),
		.dos_off (dos_off)
	);

	zdos u_zdos (
		.fclk    (fclk),
		.rst     (rst),
		.dos_on  (dos_on),
		.dos_off (dos_off),
		.dos     (dos)
	);

	// beeper or covox
	sound u_sound (
		.fclk    (fclk),
		.rst     (rst),
		.beeper  (beeper),
		.covox   (covox),
		.sysconf (sysconf),
		.beep    (beep)
	);

endmodule

// ==== hdl/sound.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module sound (
	input  logic                  fclk,
	input  logic                  rst,
	input  logic                  beeper,
	input  logic [`ZX_DATA_W-1:0] covox,
	input  logic [`ZX_DATA_W-1:0] sysconf,
	output logic                  beep
);

	// pwm period is 256 fclk
	logic [7:0] pwm_cnt;

	always_ff @(posedge fclk) begin
		if (rst)
			pwm_cnt <= '0;
		else
			pwm_cnt <= pwm_cnt + 8'd1;
	end

	// covox duty equals its value out of 256
	always_ff @(posedge fclk) begin
		if (rst)
			beep <= 1'b0;
		else if (sysconf[`ZX_COVOX_BIT])
			beep <= pwm_cnt < covox;
		else
			beep <= beeper;
	end

endmodule

// ==== hdl/zdos.sv ====
`timescale 1ns/1ps

module zdos (
	input  logic fclk,
	input  logic rst,
	input  logic dos_on,
	input  logic dos_off,
	output logic dos
);

	// set wins over clear
	always_ff @(posedge fclk) begin
		if (rst)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

	// pager cannot see one fetch both inside and outside window 0
	a_dos_excl: assert property (@(posedge fclk) disable iff (rst)
		!(dos_on && dos_off));

endmodule

// ==== pager/pager.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module pager (
	input  logic                  fclk,
	input  logic                  rst,
	zbus_if.sink                  bus,
	page_cfg_if.sink              cfg,
	input  logic                  dos,
	output logic [`ZX_PAGE_W-1:0] page,
	output logic                  romnram,
	output logic                  rw_en,
	output logic                  dos_on,
	output logic                  dos_off
);
	import zx_pkg::*;

	port_addr_u addr;
	logic [1:0] win;
	logic       rom128, w0_we, w0_ram;
	logic       w0_rom;

	assign addr   = bus.addr;
	assign win    = addr.word[`ZX_ADDR_W-1 -: 2];
	assign rom128 = cfg.memconf[0];
	assign w0_we  = cfg.memconf[1];
	assign w0_ram = cfg.memconf[3];
	assign w0_rom = (win == 2'd0) && !w0_ram;

	////////////////////
	// window mapping
	////////////////////

	// mapping is held between memory cycles
	always_ff @(posedge fclk) begin
		if (rst) begin
			page    <= '0;
			romnram <= 1'b0;
			rw_en   <= 1'b0;
		end else if (bus.mreq) begin
			case (win)
				2'd0: begin
					// rom low bits come from dos and 7FFD
					page    <= w0_ram ? cfg.page0 : {cfg.page0[7:2], ~dos, rom128};
					romnram <= ~w0_ram;
					rw_en   <= w0_ram | w0_we;
				end
				2'd1: {page, romnram, rw_en} <= {cfg.page1, 1'b0, 1'b1};
				2'd2: {page, romnram, rw_en} <= {cfg.page2, 1'b0, 1'b1};
				default: {page, romnram, rw_en} <= {cfg.page3, 1'b0, 1'b1};
			endcase
		end
	end

	// dos entry on 3Dxx fetch from basic48 rom
	always_ff @(posedge fclk) begin
		if (rst) begin
			dos_on  <= 1'b0;
			dos_off <= 1'b0;
		end else begin
			dos_on  <= bus.fetch && w0_rom && rom128 && (addr.hl.hi == `ZX_DOS_HI);
			dos_off <= bus.fetch && (win != 2'd0);
		end
	end

endmodule

// ==== ports/zports.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module zports (
	input  logic                  fclk,
	input  logic                  rst,
	zbus_if.sink                  bus,
	page_cfg_if.source            cfg,
	output logic [`ZX_DATA_W-1:0] d_out,
	output logic                  d_out_en,
	output logic [`ZX_DATA_W-1:0] sysconf,
	output logic                  beeper,
	output logic [`ZX_DATA_W-1:0] covox
);
	import zx_pkg::*;

	localparam logic [7:0] PAGE0_HI = `ZX_PAGE0_HI;

	port_addr_u            port;
	logic [`ZX_DATA_W-1:0] memconf;
	logic [`ZX_PAGE_W-1:0] page_q [4];
	logic [7:0]            page_off;
	logic [1:0]            page_idx;
	logic                  is_xport;
	logic                  sel_sys, sel_mem, sel_page;
	logic [`ZX_DATA_W-1:0] rd_val;

	////////////////////
	// port decode
	////////////////////

	assign port     = bus.addr;
	assign is_xport = port.hl.lo == `ZX_XPORT_LO;
	assign page_off = port.hl.hi - PAGE0_HI;
	assign page_idx = page_off[1:0];

	assign sel_sys  = is_xport && (port.hl.hi == `ZX_SYSCONF_HI);
	assign sel_mem  = is_xport && (port.hl.hi == `ZX_MEMCONF_HI);
	// 10AF..13AF
	assign sel_page = is_xport && (page_off < 8'd4);

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			sysconf   <= '0;
			memconf   <= '0;
			page_q[0] <= '0;
			page_q[1] <= `ZX_PAGE1_RST;
			page_q[2] <= `ZX_PAGE2_RST;
			page_q[3] <= `ZX_PAGE3_RST;
			beeper    <= 1'b0;
			covox     <= '0;
		end else if (bus.iowr) begin
			if (sel_sys)
				sysconf <= bus.data;
			if (sel_mem)
				memconf <= bus.data;
			if (sel_page)
				page_q[page_idx] <= bus.data;
			// 128K paging, ram page low bits and rom select
			if (port.word == `ZX_P7FFD) begin
				page_q[3][2:0] <= bus.data[2:0];
				memconf[0]     <= bus.data[4];
			end
			if (port.hl.lo == `ZX_PFE)
				beeper <= bus.data[4];
			if (port.hl.lo == `ZX_PFB)
				covox <= bus.data;
		end
	end

	always_comb begin
		rd_val = page_q[page_idx];
		if (sel_sys)
			rd_val = sysconf;
		else if (sel_mem)
			rd_val = memconf;
	end

	// readback, only for known extended ports
	always_ff @(posedge fclk) begin
		if (rst)
			d_out_en <= 1'b0;
		else
			d_out_en <= bus.iord & (sel_sys | sel_mem | sel_page);
	end

	always_ff @(posedge fclk)
		d_out <= rd_val;

	assign cfg.memconf = memconf;
	assign cfg.page0   = page_q[0];
	assign cfg.page1   = page_q[1];
	assign cfg.page2   = page_q[2];
	assign cfg.page3   = page_q[3];

	a_dout_after_iord: assert property (@(posedge fclk) disable iff (rst)
		d_out_en |-> $past(bus.iord));

endmodule

// ==== hdl/zsignals.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module zsignals (
	input  logic                  fclk,
	input  logic                  rst,
	input  logic                  iorq_n,
	input  logic                  mreq_n,
	input  logic                  m1_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [`ZX_ADDR_W-1:0] a,
	input  logic [`ZX_DATA_W-1:0] d_in,
	zbus_if.source                bus
);
	import zx_pkg::*;

	localparam int SYNC_W = 5 + `ZX_ADDR_W + `ZX_DATA_W;

	logic [SYNC_W-1:0]     sync_q [`ZX_SYNC_STAGES];
	logic                  iorq_s, mreq_s, m1_s, rd_s, wr_s;
	port_addr_u            a_s;
	logic [`ZX_DATA_W-1:0] d_s;
	logic                  io_wr_c, io_rd_c, fetch_c;
	logic                  io_wr_d, fetch_d;

	////////////////////
	// synchronizer
	////////////////////

	// strobes enter as active high so reset means idle
	always_ff @(posedge fclk) begin
		if (rst) begin
			for (int i = 0; i < `ZX_SYNC_STAGES; i++)
				sync_q[i] <= '0;
		end else begin
			sync_q[0] <= {~iorq_n, ~mreq_n, ~m1_n, ~rd_n, ~wr_n, a, d_in};
			for (int i = 1; i < `ZX_SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign {iorq_s, mreq_s, m1_s, rd_s, wr_s, a_s, d_s} = sync_q[`ZX_SYNC_STAGES-1];

	// no i/o during M1, that is int acknowledge
	assign io_wr_c = iorq_s & wr_s & ~m1_s;
	assign io_rd_c = iorq_s & rd_s & ~m1_s;
	assign fetch_c = mreq_s & m1_s & rd_s;

	////////////////////
	// strobe edges
	////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			io_wr_d   <= 1'b0;
			fetch_d   <= 1'b0;
			bus.iowr  <= 1'b0;
			bus.fetch <= 1'b0;
			bus.iord  <= 1'b0;
			bus.mreq  <= 1'b0;
		end else begin
			io_wr_d   <= io_wr_c;
			fetch_d   <= fetch_c;
			bus.iowr  <= io_wr_c & ~io_wr_d;
			bus.fetch <= fetch_c & ~fetch_d;
			bus.iord  <= io_rd_c;
			bus.mreq  <= mreq_s;
		end
	end

	assign bus.addr = a_s;
	assign bus.data = d_s;

	a_wr_fetch_excl: assert property (@(posedge fclk) disable iff (rst)
		!(bus.iowr && bus.fetch));

endmodule

// ==== common/page_cfg_if.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

// memory config from the port registers to the pager
interface page_cfg_if;

	// bit 0 rom128, bit 1 w0_we, bit 3 w0_ram
	logic [`ZX_DATA_W-1:0] memconf;
	logic [`ZX_PAGE_W-1:0] page0;
	logic [`ZX_PAGE_W-1:0] page1;
	logic [`ZX_PAGE_W-1:0] page2;
	logic [`ZX_PAGE_W-1:0] page3;

	modport source (output memconf, page0, page1, page2, page3);

	modport sink (input memconf, page0, page1, page2, page3);

endinterface

// ==== common/zbus_if.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

// cpu bus after the synchronizer, in fclk domain
interface zbus_if;
	import zx_pkg::*;

	port_addr_u            addr;
	logic [`ZX_DATA_W-1:0] data;
	// single cycle pulses
	logic                  iowr;
	logic                  fetch;
	// levels
	logic                  iord;
	logic                  mreq;

	modport source (
		output addr, data, iowr, iord, fetch, mreq
	);

	modport sink (
		input addr, data, iowr, iord, fetch, mreq
	);

endinterface

// ==== common/zx_pkg.sv ====
`include "zx_cfg.svh"

package zx_pkg;

	// port address, read either as a full word or as hi/lo bytes
	typedef struct packed {
		logic [`ZX_ADDR_W/2-1:0] hi;
		logic [`ZX_ADDR_W/2-1:0] lo;
	} port_bytes_t;

	typedef union packed {
		// full decode, 7FFD
		logic [`ZX_ADDR_W-1:0] word;
		// xxAF ports, hi selects the register
		port_bytes_t           hl;
	} port_addr_u;

endpackage

// ==== common/zx_cfg.svh ====
`ifndef ZX_CFG_SVH
`define ZX_CFG_SVH

// bus widths
`define ZX_ADDR_W 16
`define ZX_DATA_W 8
`define ZX_PAGE_W 8

// extended ports live at xxAF, high byte picks the register
`define ZX_XPORT_LO   8'hAF
`define ZX_SYSCONF_HI 8'h00
`define ZX_MEMCONF_HI 8'h21
`define ZX_PAGE0_HI   8'h10

// legacy ports
`define ZX_P7FFD 16'h7FFD
`define ZX_PFE   8'hFE
`define ZX_PFB   8'hFB

// TR-DOS trap area, high address byte
`define ZX_DOS_HI 8'h3D

`define ZX_SYNC_STAGES 2

// window page reset values
`define ZX_PAGE1_RST 8'h05
`define ZX_PAGE2_RST 8'h02
`define ZX_PAGE3_RST 8'h00

// sysconf bit selecting covox PWM over beeper
`define ZX_COVOX_BIT 4

`endif
